// ==== design/csr_consts.svh ====
`ifndef CSR_CONSTS_SVH
`define CSR_CONSTS_SVH

// Data width
`define XLEN 32

// Machine trap setup
`define CSR_MSTATUS  12'h300
`define CSR_MISA     12'h301
`define CSR_MIE      12'h304
`define CSR_MTVEC    12'h305

// Machine trap handling
`define CSR_MSCRATCH 12'h340
`define CSR_MEPC     12'h341
`define CSR_MCAUSE   12'h342
`define CSR_MTVAL    12'h343
`define CSR_MIP      12'h344

// Exception causes
`define CAUSE_ILLEGAL 2
`define CAUSE_ECALL_U 8
`define CAUSE_ECALL_M 11

// Interrupt codes, also the bit positions in mie and mip
`define IRQ_MTI 7
`define IRQ_MEI 11

// mstatus fields
`define MSTATUS_MIE_BIT  3
`define MSTATUS_MPIE_BIT 7
`define MSTATUS_MPP_LSB  11

// mtvec mode field
`define MTVEC_MODE_DIRECT   2'b00
`define MTVEC_MODE_VECTORED 2'b01

// MXL = 1 (32 bit), extension I only
`define MISA_VALUE 32'h4000_0100

`endif

// ==== design/csr_pkg.sv ====
`default_nettype none

`include "csr_consts.svh"

package csr_pkg;

    typedef logic [`XLEN-1:0] xlen_t;
    typedef logic [11:0]      csr_addr_t;
    // Bit 31 set for an interrupt
    typedef logic [`XLEN-1:0] cause_t;
    typedef logic [63:0]      mtime_t;

    typedef enum logic [1:0] {
        PRIV_U = 2'd0,
        PRIV_M = 2'd3
    } priv_t;

    typedef enum logic [2:0] {
        CMD_NONE  = 3'd0,
        CMD_WRITE = 3'd1,
        CMD_SET   = 3'd2,
        CMD_CLEAR = 3'd3,
        CMD_ECALL = 3'd4,
        CMD_MRET  = 3'd5
    } csr_cmd_t;

    typedef struct packed {
        csr_cmd_t  cmd;
        csr_addr_t addr;
        xlen_t     operand;
        xlen_t     pc;
        xlen_t     inst;
        logic      expt_valid;
        cause_t    expt_cause;
    } csr_req_t;

    typedef struct packed {
        xlen_t rdata;
        logic  trap;
        logic  redirect;
        xlen_t target;
        logic  no_wb;
    } csr_resp_t;

    typedef struct packed {
        priv_t priv;
        logic  mie;
        priv_t mpp;
        logic  mpie;
        xlen_t mtvec;
        xlen_t mepc;
        // mip & mie
        xlen_t irq_act;
        xlen_t irq_en;
    } csr_view_t;

    typedef struct packed {
        logic   raise;
        logic   is_irq;
        cause_t cause;
        xlen_t  tval;
        xlen_t  target;
    } trap_info_t;

    typedef struct packed {
        logic   do_write;
        xlen_t  wdata;
        logic   do_trap;
        logic   do_mret;
        cause_t cause;
        xlen_t  tval;
        xlen_t  epc;
        xlen_t  clear_mip;
    } csr_update_t;

endpackage

`default_nettype wire

// ==== design/csr_file.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_file import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  csr_addr_t   addr,
    input  csr_cmd_t    cmd,
    input  xlen_t       operand,
    input  logic        ext_irq,
    input  mtime_t      mtime,
    input  mtime_t      mtimecmp,
    input  csr_update_t upd,
    output xlen_t       rdata,
    output xlen_t       wdata,
    output csr_view_t   view,
    output priv_t       priv
);

    priv_t priv_q;
    logic  mstatus_mie;
    logic  mstatus_mpie;
    priv_t mstatus_mpp;
    logic  mie_meie;
    logic  mie_mtie;
    logic  mip_meip;
    logic  mip_mtip;
    xlen_t mtvec;
    xlen_t mepc;
    xlen_t mscratch;
    xlen_t mcause;
    xlen_t mtval;
    xlen_t mstatus_word;
    xlen_t mie_word;
    xlen_t mip_word;

    always_comb begin
        mstatus_word = '0;
        mstatus_word[`MSTATUS_MIE_BIT] = mstatus_mie;
        mstatus_word[`MSTATUS_MPIE_BIT] = mstatus_mpie;
        mstatus_word[`MSTATUS_MPP_LSB +: 2] = mstatus_mpp;
        mie_word = '0;
        mie_word[`IRQ_MEI] = mie_meie;
        mie_word[`IRQ_MTI] = mie_mtie;
        mip_word = '0;
        mip_word[`IRQ_MEI] = mip_meip;
        mip_word[`IRQ_MTI] = mip_mtip;
    end

    // Read decode, unknown addresses read zero
    always_comb begin
        case (addr)
            `CSR_MSTATUS:  rdata = mstatus_word;
            `CSR_MISA:     rdata = `MISA_VALUE;
            `CSR_MIE:      rdata = mie_word;
            `CSR_MIP:      rdata = mip_word;
            `CSR_MTVEC:    rdata = mtvec;
            `CSR_MSCRATCH: rdata = mscratch;
            `CSR_MEPC:     rdata = mepc;
            `CSR_MCAUSE:   rdata = mcause;
            `CSR_MTVAL:    rdata = mtval;
            default:       rdata = '0;
        endcase
    end

    always_comb begin
        case (cmd)
            CMD_WRITE: wdata = operand;
            CMD_SET:   wdata = rdata | operand;
            CMD_CLEAR: wdata = rdata & ~operand;
            default:   wdata = rdata;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            priv_q       <= PRIV_M;
            mstatus_mie  <= 1'b0;
            mstatus_mpie <= 1'b0;
            mstatus_mpp  <= PRIV_U;
            mie_meie     <= 1'b0;
            mie_mtie     <= 1'b0;
            mip_meip     <= 1'b0;
            mip_mtip     <= 1'b0;
            mtvec        <= '0;
            mepc         <= '0;
        end else begin
            // Pending bits follow their sources, except the one just taken
            mip_meip <= ext_irq & ~upd.clear_mip[`IRQ_MEI];
            mip_mtip <= (mtime >= mtimecmp) & ~upd.clear_mip[`IRQ_MTI];
            if (upd.do_trap) begin
                priv_q       <= PRIV_M;
                mstatus_mpp  <= priv_q;
                mstatus_mpie <= mstatus_mie;
                mstatus_mie  <= 1'b0;
                mepc         <= upd.epc;
            end else if (upd.do_mret) begin
                priv_q       <= mstatus_mpp;
                mstatus_mpp  <= PRIV_U;
                mstatus_mie  <= mstatus_mpie;
                mstatus_mpie <= 1'b1;
            end else if (upd.do_write) begin
                case (addr)
                    `CSR_MSTATUS: begin
                        mstatus_mie  <= upd.wdata[`MSTATUS_MIE_BIT];
                        mstatus_mpie <= upd.wdata[`MSTATUS_MPIE_BIT];
                        // Only U and M exist, anything else maps to U
                        mstatus_mpp  <= (upd.wdata[`MSTATUS_MPP_LSB +: 2] == 2'b11) ?
                                        PRIV_M : PRIV_U;
                    end
                    `CSR_MIE: begin
                        mie_meie <= upd.wdata[`IRQ_MEI];
                        mie_mtie <= upd.wdata[`IRQ_MTI];
                    end
                    // Mode bit 1 is reserved
                    `CSR_MTVEC: mtvec <= {upd.wdata[`XLEN-1:2], 1'b0, upd.wdata[0]};
                    `CSR_MEPC:  mepc  <= {upd.wdata[`XLEN-1:2], 2'b00};
                    default: begin
                    end
                endcase
            end
        end
    end

    always_ff @(posedge clk) begin
        if (upd.do_trap) begin
            mcause <= upd.cause;
            mtval  <= upd.tval;
        end else if (upd.do_write) begin
            case (addr)
                `CSR_MSCRATCH: mscratch <= upd.wdata;
                `CSR_MCAUSE:   mcause   <= upd.wdata;
                `CSR_MTVAL:    mtval    <= upd.wdata;
                default: begin
                end
            endcase
        end
    end

    always_comb begin
        view.priv    = priv_q;
        view.mie     = mstatus_mie;
        view.mpp     = mstatus_mpp;
        view.mpie    = mstatus_mpie;
        view.mtvec   = mtvec;
        view.mepc    = mepc;
        view.irq_act = mip_word & mie_word;
        view.irq_en  = mie_word;
    end

    assign priv = priv_q;

endmodule

`default_nettype wire

// ==== design/trap_check.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_consts.svh"

module trap_check import csr_pkg::*; (
    input  csr_req_t   req,
    input  csr_view_t  view,
    output trap_info_t info
);

    logic       is_write;
    logic       read_only;
    logic       no_priv;
    logic       illegal;
    logic       ecall;
    logic       expt;
    cause_t     expt_cause;
    logic       irq_take;
    logic [4:0] irq_code;
    cause_t     irq_cause;
    xlen_t      base;

    assign is_write = req.cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR};

    // Top two address bits mark a read-only CSR; misa is fixed here as well
    assign read_only = (req.addr[11:10] == 2'b11) || (req.addr == `CSR_MISA);
    // Bits 9:8 give the lowest privilege allowed
    assign no_priv   = req.addr[9:8] > view.priv;

    assign illegal = (is_write && (read_only || no_priv)) ||
                     (req.cmd == CMD_MRET && view.priv != PRIV_M);
    assign ecall   = req.cmd == CMD_ECALL;
    assign expt    = req.expt_valid || ecall || illegal;

    // Earlier stages win
    always_comb begin
        if (req.expt_valid) begin
            expt_cause = req.expt_cause;
        end else if (ecall) begin
            expt_cause = (view.priv == PRIV_U) ? cause_t'(`CAUSE_ECALL_U) :
                                                 cause_t'(`CAUSE_ECALL_M);
        end else begin
            expt_cause = cause_t'(`CAUSE_ILLEGAL);
        end
    end

    // Always enabled in U mode, gated by MIE in M mode
    assign irq_take = !expt && (|view.irq_act) && (view.priv == PRIV_U || view.mie);
    // External before timer
    assign irq_code = view.irq_act[`IRQ_MEI] ? 5'(`IRQ_MEI) : 5'(`IRQ_MTI);

    always_comb begin
        irq_cause = '0;
        irq_cause[`XLEN-1] = 1'b1;
        irq_cause[4:0] = irq_code;
    end

    assign base = {view.mtvec[`XLEN-1:2], 2'b00};

    always_comb begin
        info.raise  = expt || irq_take;
        info.is_irq = irq_take;
        info.cause  = expt ? expt_cause : irq_cause;
        if (req.expt_valid) begin
            info.tval = req.pc;
        end else if (illegal) begin
            info.tval = req.inst;
        end else begin
            info.tval = '0;
        end
        if (irq_take && view.mtvec[1:0] == `MTVEC_MODE_VECTORED) begin
            info.target = base + xlen_t'({irq_code, 2'b00});
        end else begin
            info.target = base;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_commit.sv ====
`default_nettype none
`timescale 1ns/1ps

module csr_commit import csr_pkg::*; (
    input  logic        clk,
    input  logic        rst,
    input  csr_req_t    req,
    input  logic        req_valid,
    output logic        req_ready,
    input  xlen_t       rdata,
    input  xlen_t       wdata,
    input  trap_info_t  info,
    input  xlen_t       mepc,
    output csr_update_t upd,
    output csr_resp_t   resp,
    output logic        resp_valid,
    input  logic        resp_ready
);

    logic      accept;
    logic      is_write;
    logic      is_mret;
    csr_resp_t resp_d;

    // Response slot is free or being drained this cycle
    assign req_ready = !resp_valid || resp_ready;
    assign accept    = req_valid && req_ready;

    assign is_write = req.cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR};
    assign is_mret  = req.cmd == CMD_MRET;

    // Trap first, then mret, then a plain CSR write
    always_comb begin
        upd.do_trap   = accept && info.raise;
        upd.do_mret   = accept && !info.raise && is_mret;
        upd.do_write  = accept && !info.raise && is_write;
        upd.wdata     = wdata;
        upd.cause     = info.cause;
        upd.tval      = info.tval;
        upd.epc       = req.pc;
        upd.clear_mip = '0;
        if (accept && info.is_irq) begin
            upd.clear_mip[info.cause[4:0]] = 1'b1;
        end
    end

    always_comb begin
        resp_d.rdata    = rdata;
        resp_d.trap     = info.raise;
        resp_d.redirect = info.raise || is_mret;
        resp_d.no_wb    = info.raise || is_mret;
        if (info.raise) begin
            resp_d.target = info.target;
        end else if (is_mret) begin
            resp_d.target = mepc;
        end else begin
            resp_d.target = '0;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            resp_valid <= 1'b0;
        end else if (accept) begin
            resp_valid <= 1'b1;
        end else if (resp_ready) begin
            resp_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            resp <= resp_d;
        end
    end

endmodule

`default_nettype wire

// ==== design/csr_unit.sv ====
`default_nettype none
`timescale 1ns/1ps

module csr_unit import csr_pkg::*; (
    input  logic      clk,
    input  logic      rst,
    input  csr_req_t  req,
    input  logic      req_valid,
    output logic      req_ready,
    output csr_resp_t resp,
    output logic      resp_valid,
    input  logic      resp_ready,
    input  logic      ext_irq,
    input  mtime_t    mtime,
    input  mtime_t    mtimecmp,
    output priv_t     priv
);

    csr_view_t   view;
    trap_info_t  info;
    csr_update_t upd;
    xlen_t       rdata;
    xlen_t       wdata;

    csr_file u_file (
        .clk      (clk),
        .rst      (rst),
        .addr     (req.addr),
        .cmd      (req.cmd),
        .operand  (req.operand),
        .ext_irq  (ext_irq),
        .mtime    (mtime),
        .mtimecmp (mtimecmp),
        .upd      (upd),
        .rdata    (rdata),
        .wdata    (wdata),
        .view     (view),
        .priv     (priv)
    );

    trap_check u_trap (
        .req  (req),
        .view (view),
        .info (info)
    );

    csr_commit u_commit (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .rdata      (rdata),
        .wdata      (wdata),
        .info       (info),
        .mepc       (view.mepc),
        .upd        (upd),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready)
    );

endmodule

`default_nettype wire

// ==== verification/csr_unit_sva.sv ====
`default_nettype none
`timescale 1ns/1ps

module csr_unit_sva import csr_pkg::*; (
    input logic      clk,
    input logic      rst,
    input logic      req_valid,
    input logic      req_ready,
    input csr_resp_t resp,
    input logic      resp_valid,
    input logic      resp_ready
);

    // Failure count, read by the testbench summary
    int fail_count = 0;

    reset_clears_resp: assert property (@(posedge clk) rst |=> !resp_valid)
        else begin
            fail_count++;
            $error("resp_valid high after reset");
        end

    // Held response must not move while the consumer stalls
    stall_holds_resp: assert property (@(posedge clk) disable iff (rst)
        resp_valid && !resp_ready |=> resp_valid && $stable(resp))
        else begin
            fail_count++;
            $error("response changed while stalled");
        end

    accept_gives_resp: assert property (@(posedge clk) disable iff (rst)
        req_valid && req_ready |=> resp_valid)
        else begin
            fail_count++;
            $error("accepted request without a response on the next cycle");
        end

    ready_rule: assert property (@(posedge clk) disable iff (rst)
        req_ready == (!resp_valid || resp_ready))
        else begin
            fail_count++;
            $error("req_ready does not follow the response slot");
        end

endmodule

bind csr_unit csr_unit_sva u_sva (
    .clk        (clk),
    .rst        (rst),
    .req_valid  (req_valid),
    .req_ready  (req_ready),
    .resp       (resp),
    .resp_valid (resp_valid),
    .resp_ready (resp_ready)
);

`default_nettype wire

// ==== verification/csr_unit_tb.sv ====
`default_nettype none
`timescale 1ns/1ps

`include "csr_consts.svh"

module csr_unit_tb import csr_pkg::*; ();

    localparam int CLK_PERIOD = 100;
    localparam int NUM_RANDOM = 40;
    localparam int NUM_REQS   = 40 + NUM_RANDOM;

    typedef struct packed {
        csr_resp_t resp;
        priv_t     priv;
        logic      check_rdata;
    } expect_t;

    logic      clk;
    logic      rst;
    csr_req_t  req;
    logic      req_valid;
    logic      req_ready;
    csr_resp_t resp;
    logic      resp_valid;
    logic      resp_ready;
    logic      ext_irq;
    mtime_t    mtime;
    mtime_t    mtimecmp;
    priv_t     priv;

    // Reference state of the kept CSRs
    priv_t m_priv;
    priv_t m_mpp;
    logic  m_mie;
    logic  m_mpie;
    logic  m_meie;
    logic  m_mtie;
    logic  scratch_set;
    xlen_t m_mtvec;
    xlen_t m_mscratch;
    xlen_t m_mepc;
    xlen_t m_mcause;
    xlen_t m_mtval;

    expect_t     exp_q[$];
    xlen_t       pc_ctr;
    logic [31:0] stall_rng;
    logic [31:0] data_rng;
    int          errors;
    int          err_mark;
    int          n_pass;
    int          n_fail;

    csr_unit UUT (
        .clk        (clk),
        .rst        (rst),
        .req        (req),
        .req_valid  (req_valid),
        .req_ready  (req_ready),
        .resp       (resp),
        .resp_valid (resp_valid),
        .resp_ready (resp_ready),
        .ext_irq    (ext_irq),
        .mtime      (mtime),
        .mtimecmp   (mtimecmp),
        .priv       (priv)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    function automatic logic [31:0] xorshift(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x = x ^ (x << 13);
        x = x ^ (x >> 17);
        x = x ^ (x << 5);
        return x;
    endfunction

    function automatic xlen_t model_read(input csr_addr_t a);
        xlen_t v;
        v = '0;
        case (a)
            `CSR_MSTATUS: begin
                v[`MSTATUS_MIE_BIT]      = m_mie;
                v[`MSTATUS_MPIE_BIT]     = m_mpie;
                v[`MSTATUS_MPP_LSB +: 2] = m_mpp;
            end
            `CSR_MISA:     v = `MISA_VALUE;
            `CSR_MIE: begin
                v[`IRQ_MEI] = m_meie;
                v[`IRQ_MTI] = m_mtie;
            end
            `CSR_MIP: begin
                v[`IRQ_MEI] = ext_irq;
                v[`IRQ_MTI] = mtime >= mtimecmp;
            end
            `CSR_MTVEC:    v = m_mtvec;
            `CSR_MSCRATCH: v = m_mscratch;
            `CSR_MEPC:     v = m_mepc;
            `CSR_MCAUSE:   v = m_mcause;
            `CSR_MTVAL:    v = m_mtval;
            default:       v = '0;
        endcase
        return v;
    endfunction

    task automatic model_write(input csr_addr_t a, input xlen_t v);
        case (a)
            `CSR_MSTATUS: begin
                m_mie  = v[`MSTATUS_MIE_BIT];
                m_mpie = v[`MSTATUS_MPIE_BIT];
                m_mpp  = (v[`MSTATUS_MPP_LSB +: 2] == 2'b11) ? PRIV_M : PRIV_U;
            end
            `CSR_MIE: begin
                m_meie = v[`IRQ_MEI];
                m_mtie = v[`IRQ_MTI];
            end
            `CSR_MTVEC: m_mtvec = v & ~32'h2;
            `CSR_MSCRATCH: begin
                m_mscratch  = v;
                scratch_set = 1'b1;
            end
            `CSR_MEPC:   m_mepc   = v & ~32'h3;
            `CSR_MCAUSE: m_mcause = v;
            `CSR_MTVAL:  m_mtval  = v;
            default: begin
            end
        endcase
    endtask

    // Expected response for an accepted request, then the state update
    task automatic predict(input csr_req_t r);
        expect_t e;
        xlen_t   old;
        xlen_t   nv;
        xlen_t   act;
        xlen_t   base;
        cause_t  cause;
        logic    wr;
        logic    ill;
        logic    expt;
        logic    irq;
        int      code;
        old  = model_read(r.addr);
        wr   = r.cmd inside {CMD_WRITE, CMD_SET, CMD_CLEAR};
        ill  = (wr && (r.addr[11:10] == 2'b11 || r.addr == `CSR_MISA || r.addr[9:8] > m_priv))
               || (r.cmd == CMD_MRET && m_priv == PRIV_U);
        expt = r.expt_valid || r.cmd == CMD_ECALL || ill;
        act  = model_read(`CSR_MIP) & model_read(`CSR_MIE);
        irq  = !expt && act != 0 && (m_priv == PRIV_U || m_mie);
        code = act[`IRQ_MEI] ? `IRQ_MEI : `IRQ_MTI;
        base = {m_mtvec[`XLEN-1:2], 2'b00};
        if (r.expt_valid) begin
            cause = r.expt_cause;
        end else if (r.cmd == CMD_ECALL) begin
            cause = (m_priv == PRIV_U) ? `CAUSE_ECALL_U : `CAUSE_ECALL_M;
        end else if (ill) begin
            cause = `CAUSE_ILLEGAL;
        end else begin
            cause = 32'h8000_0000 | xlen_t'(code);
        end
        case (r.cmd)
            CMD_SET:   nv = old | r.operand;
            CMD_CLEAR: nv = old & ~r.operand;
            default:   nv = r.operand;
        endcase
        e.check_rdata   = !(r.addr == `CSR_MSCRATCH && !scratch_set);
        e.resp.rdata    = old;
        e.resp.trap     = expt || irq;
        e.resp.redirect = expt || irq || r.cmd == CMD_MRET;
        e.resp.no_wb    = e.resp.redirect;
        e.resp.target   = '0;
        if (expt || irq) begin
            e.resp.target = base;
            if (irq && m_mtvec[1:0] == `MTVEC_MODE_VECTORED) begin
                e.resp.target = base + xlen_t'(code * 4);
            end
            m_mcause = cause;
            m_mtval  = r.expt_valid ? r.pc : (ill ? r.inst : '0);
            m_mepc   = r.pc;
            m_mpie   = m_mie;
            m_mie    = 1'b0;
            m_mpp    = m_priv;
            m_priv   = PRIV_M;
        end else if (r.cmd == CMD_MRET) begin
            e.resp.target = m_mepc;
            m_priv = m_mpp;
            m_mie  = m_mpie;
            m_mpie = 1'b1;
            m_mpp  = PRIV_U;
        end else if (wr) begin
            model_write(r.addr, nv);
        end
        e.priv = m_priv;
        exp_q.push_back(e);
    endtask

    task automatic send(input csr_req_t r);
        logic acc;
        r.pc   = pc_ctr;
        pc_ctr = pc_ctr + 4;
        req       = r;
        req_valid = 1'b1;
        acc       = 1'b0;
        while (!acc) begin
            @(negedge clk);
            if (req_ready) begin
                acc = 1'b1;
                predict(r);
            end
            @(posedge clk);
            #1;
        end
        req_valid = 1'b0;
    endtask

    task automatic csr_op(input csr_cmd_t cmd, input csr_addr_t addr, input xlen_t operand);
        csr_req_t r;
        r            = '0;
        r.cmd        = cmd;
        r.addr       = addr;
        r.operand    = operand;
        // CSR-type encoding with the address in the top bits
        r.inst       = {addr, 5'd1, 3'b001, 5'd2, 7'h73};
        send(r);
    endtask

    task automatic pass_expt(input cause_t cause);
        csr_req_t r;
        r            = '0;
        r.inst       = 32'h0000_0013;
        r.expt_valid = 1'b1;
        r.expt_cause = cause;
        send(r);
    endtask

    task automatic idle(input int n);
        repeat (n) @(posedge clk);
        #1;
    endtask

    task automatic end_test(input string name);
        while (exp_q.size() != 0) @(posedge clk);
        #1;
        if (errors == err_mark) begin
            n_pass++;
        end else begin
            n_fail++;
        end
        $display("Test %s: %s, %0d errors", name, (errors == err_mark) ? "ok" : "failed",
                 errors - err_mark);
        err_mark = errors;
    endtask

    // Stall the consumer about one cycle in four
    always @(posedge clk) begin
        #1;
        stall_rng  = xorshift(stall_rng);
        resp_ready = rst || (stall_rng[1:0] != 2'b00);
    end

    // Compare on the edge before the transfer, where resp and priv are stable
    always @(negedge clk) begin : check_resp
        expect_t   e;
        csr_resp_t got;
        if (!rst && resp_valid && resp_ready) begin
            if (exp_q.size() == 0) begin
                $display("Response at %0t with no request outstanding", $time);
                errors++;
            end else begin
                e   = exp_q.pop_front();
                got = resp;
                // First mscratch read has no defined value
                if (!e.check_rdata) begin
                    got.rdata    = '0;
                    e.resp.rdata = '0;
                end
                assert (got == e.resp) else begin
                    $display("Mismatch at %0t: resp %h, expected %h", $time, resp, e.resp);
                    errors++;
                end
                assert (priv == e.priv) else begin
                    $display("Mismatch at %0t: priv %0d, expected %0d", $time, priv, e.priv);
                    errors++;
                end
            end
        end
    end

    initial begin
        #(CLK_PERIOD * (NUM_REQS * 20 + 10));
        $display("Timeout: run did not finish within %0d cycles", NUM_REQS * 20 + 10);
        $display("FAIL: see errors above");
        $finish;
    end

    initial begin
        csr_cmd_t  cmd;
        csr_addr_t addr;
        int        total;
        clk = 1'b0;
        rst = 1'b1;
        req = '0;
        req_valid  = 1'b0;
        resp_ready = 1'b1;
        ext_irq    = 1'b0;
        mtime      = 64'd0;
        mtimecmp   = '1;
        m_priv = PRIV_M;
        m_mpp  = PRIV_U;
        m_mie  = 1'b0;
        m_mpie = 1'b0;
        m_meie = 1'b0;
        m_mtie = 1'b0;
        scratch_set = 1'b0;
        m_mtvec    = '0;
        m_mscratch = '0;
        m_mepc     = '0;
        m_mcause   = '0;
        m_mtval    = '0;
        pc_ctr    = 32'h8000_0000;
        stall_rng = 32'h15cf2f94;
        data_rng  = xorshift(32'h15cf2f94);
        errors   = 0;
        err_mark = 0;
        n_pass   = 0;
        n_fail   = 0;
        repeat (2) @(posedge clk);
        #1;
        rst = 1'b0;

        csr_op(CMD_WRITE, `CSR_MSCRATCH, 32'hdead_beef);
        csr_op(CMD_SET, `CSR_MSCRATCH, 32'h0000_ff00);
        csr_op(CMD_CLEAR, `CSR_MSCRATCH, 32'hf000_000f);
        csr_op(CMD_NONE, `CSR_MSCRATCH, '0);
        csr_op(CMD_WRITE, `CSR_MTVEC, 32'h0000_1003);
        csr_op(CMD_SET, `CSR_MTVEC, 32'h0000_0200);
        csr_op(CMD_CLEAR, `CSR_MTVEC, 32'h0000_0001);
        csr_op(CMD_NONE, `CSR_MTVEC, '0);
        end_test("csr_rw");

        csr_op(CMD_WRITE, `CSR_MISA, '0);
        csr_op(CMD_NONE, `CSR_MISA, '0);
        csr_op(CMD_CLEAR, `CSR_MSTATUS, 32'h0000_1800);
        csr_op(CMD_WRITE, `CSR_MEPC, 32'h0000_2000);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_WRITE, `CSR_MSTATUS, 32'h0000_0008);
        csr_op(CMD_NONE, `CSR_MSTATUS, '0);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_MRET, '0, '0);
        end_test("illegal");

        csr_op(CMD_ECALL, '0, '0);
        csr_op(CMD_NONE, `CSR_MEPC, '0);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_WRITE, `CSR_MEPC, 32'h0000_3000);
        csr_op(CMD_MRET, '0, '0);
        csr_op(CMD_ECALL, '0, '0);
        csr_op(CMD_NONE, `CSR_MEPC, '0);
        csr_op(CMD_NONE, `CSR_MCAUSE, '0);
        csr_op(CMD_MRET, '0, '0);
        pass_expt(32'd5);
        csr_op(CMD_NONE, `CSR_MTVAL, '0);
        csr_op(CMD_NONE, `CSR_MCAUSE, '0);
        end_test("ecall_mret");

        csr_op(CMD_WRITE, `CSR_MTVEC, 32'h0000_1201);
        csr_op(CMD_WRITE, `CSR_MIE, 32'h0000_0080);
        csr_op(CMD_SET, `CSR_MSTATUS, 32'h0000_0008);
        mtime    = 64'd100;
        mtimecmp = 64'd50;
        idle(2);
        csr_op(CMD_WRITE, `CSR_MSCRATCH, 32'h0000_1234);
        mtimecmp = '1;
        idle(2);
        csr_op(CMD_NONE, `CSR_MSCRATCH, '0);
        csr_op(CMD_NONE, `CSR_MCAUSE, '0);
        csr_op(CMD_WRITE, `CSR_MIE, 32'h0000_0880);
        ext_irq  = 1'b1;
        mtimecmp = 64'd50;
        idle(2);
        csr_op(CMD_SET, `CSR_MSTATUS, 32'h0000_0008);
        csr_op(CMD_NONE, `CSR_MSCRATCH, '0);
        ext_irq  = 1'b0;
        mtimecmp = '1;
        idle(2);
        csr_op(CMD_WRITE, `CSR_MIE, '0);
        csr_op(CMD_NONE, `CSR_MCAUSE, '0);
        end_test("interrupts");

        repeat (NUM_RANDOM) begin
            data_rng = xorshift(data_rng);
            cmd = csr_cmd_t'({1'b0, data_rng[1:0]});
            case (data_rng[3:2])
                2'd0:    addr = `CSR_MSCRATCH;
                2'd1:    addr = `CSR_MCAUSE;
                2'd2:    addr = `CSR_MTVAL;
                default: addr = `CSR_MEPC;
            endcase
            data_rng = xorshift(data_rng);
            csr_op(cmd, addr, data_rng);
        end
        end_test("random_stall");

        total = errors + UUT.u_sva.fail_count;
        $display("Tests %0d passed, %0d failed, %0d check errors, %0d assertion failures",
                 n_pass, n_fail, errors, UUT.u_sva.fail_count);
        if (total == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== vlog.f ====
+incdir+design
design/csr_pkg.sv
design/csr_file.sv
design/trap_check.sv
design/csr_commit.sv
design/csr_unit.sv
verification/csr_unit_sva.sv
verification/csr_unit_tb.sv

// ==== run.sh ====
#!/bin/sh

if ! verilator --binary --timing --assert --timescale 1ns/1ps \
        --top-module csr_unit_tb -Mdir obj_dir -f vlog.f; then
    echo "Verilator build failed"
    exit 1
fi

if ! out=$(./obj_dir/Vcsr_unit_tb +verilator+error+limit+1000); then
    printf '%s\n' "$out"
    echo "Simulation exited with an error status"
    exit 1
fi
printf '%s\n' "$out"

if printf '%s\n' "$out" | grep -qx 'PASS: all tests'; then
    exit 0
fi
exit 1
